// ==== hdl/time_link_config.svh ====
`ifndef TIME_LINK_CONFIG_SVH
`define TIME_LINK_CONFIG_SVH

// bits in one master time word, a whole number of bytes.
`define TIME_WIDTH 32

// bits in one 8b/10b code group.
`define SYMBOL_BITS 10

// K28.5, sent between frames and used for symbol alignment.
`define COMMA_CHAR 8'hBC

// K28.1, marks the start of a time frame.
`define HEAD_CHAR 8'h3C

`endif

// ==== hdl/line_code_pkg.sv ====
`include "time_link_config.svh"

package line_code_pkg;

   // unencoded byte, HGF EDCBA with A in bit 0.
   typedef logic [7:0] data_byte_t;

   // encoded group, bit 0 is line bit a and goes out first.
   typedef logic [`SYMBOL_BITS-1:0] code_group_t;

   // 1 means positive running disparity.
   typedef logic running_disp_t;

endpackage

// ==== hdl/time_pkg.sv ====
`include "time_link_config.svh"

package time_pkg;

   typedef logic [`TIME_WIDTH-1:0] time_word_t;

   // one data state per time byte, most significant byte first.
   typedef enum logic [2:0]
   {
      SEND_IDLE,
      SEND_HEAD,
      SEND_T0,
      SEND_T1,
      SEND_T2,
      SEND_T3
   } send_state_t;

   typedef enum logic [1:0]
   {
      RECV_HUNT,
      RECV_WAIT_HEAD,
      RECV_COLLECT
   } recv_state_t;

endpackage

// ==== hdl/encode_8b10b.sv ====
`timescale 1ns/10ps

module encode_8b10b
   import line_code_pkg::*;
(
   input  data_byte_t    datain,
   input  logic          k,
   input  running_disp_t dispin,
   output code_group_t   dataout,
   output running_disp_t dispout
);

   logic [4:0]    x;
   logic [2:0]    y;
   logic [5:0]    six_base;
   logic [5:0]    six;
   logic [3:0]    four_base;
   logic [3:0]    four;
   logic [9:0]    flat;
   logic          k28;
   logic          six_unbal;
   logic          four_unbal;
   logic          alt7;
   logic          flip4;
   running_disp_t rd6;

   assign x = datain[4:0];
   assign y = datain[7:5];
   assign k28 = k && (x == 5'd28);

   // 5b/6b, listed as abcdei in the negative disparity form.
   always_comb
   begin
      case (x)
         5'd0:  six_base = 6'b100111;
         5'd1:  six_base = 6'b011101;
         5'd2:  six_base = 6'b101101;
         5'd3:  six_base = 6'b110001;
         5'd4:  six_base = 6'b110101;
         5'd5:  six_base = 6'b101001;
         5'd6:  six_base = 6'b011001;
         5'd7:  six_base = 6'b111000;
         5'd8:  six_base = 6'b111001;
         5'd9:  six_base = 6'b100101;
         5'd10: six_base = 6'b010101;
         5'd11: six_base = 6'b110100;
         5'd12: six_base = 6'b001101;
         5'd13: six_base = 6'b101100;
         5'd14: six_base = 6'b011100;
         5'd15: six_base = 6'b010111;
         5'd16: six_base = 6'b011011;
         5'd17: six_base = 6'b100011;
         5'd18: six_base = 6'b010011;
         5'd19: six_base = 6'b110010;
         5'd20: six_base = 6'b001011;
         5'd21: six_base = 6'b101010;
         5'd22: six_base = 6'b011010;
         5'd23: six_base = 6'b111010;
         5'd24: six_base = 6'b110011;
         5'd25: six_base = 6'b100110;
         5'd26: six_base = 6'b010110;
         5'd27: six_base = 6'b110110;
         5'd28: six_base = k28 ? 6'b001111 : 6'b001110;
         5'd29: six_base = 6'b101110;
         5'd30: six_base = 6'b011110;
         default: six_base = 6'b101011;
      endcase

      six_unbal = ($countones(six_base) != 3);
      // D.07 is balanced but still has two forms.
      six = (dispin && (six_unbal || x == 5'd7)) ? ~six_base : six_base;
      rd6 = six_unbal ? ~dispin : dispin;

      // alternate 7 avoids a run of five on the 6b/4b seam.
      alt7 = (y == 3'd7) && (k ||
             (!rd6 && (x == 5'd17 || x == 5'd18 || x == 5'd20)) ||
             (rd6 && (x == 5'd11 || x == 5'd13 || x == 5'd14)));

      case (y)
         3'd0: four_base = 4'b1011;
         3'd1: four_base = 4'b1001;
         3'd2: four_base = 4'b0101;
         3'd3: four_base = 4'b1100;
         3'd4: four_base = 4'b1101;
         3'd5: four_base = 4'b1010;
         3'd6: four_base = 4'b0110;
         default: four_base = alt7 ? 4'b0111 : 4'b1110;
      endcase

      four_unbal = ($countones(four_base) != 2);
      // K28 swaps its balanced 4b codes after a negative 6b block.
      flip4 = (rd6 && (four_unbal || y == 3'd3)) ||
              (k28 && !rd6 && !four_unbal && y != 3'd3);
      four = flip4 ? ~four_base : four_base;
      dispout = four_unbal ? ~rd6 : rd6;

      flat = {six, four};
      for (int i = 0; i < 10; i++)
         dataout[i] = flat[9-i];
   end

endmodule

// ==== hdl/decode_8b10b.sv ====
`timescale 1ns/10ps

module decode_8b10b
   import line_code_pkg::*;
(
   input  code_group_t   datain,
   input  running_disp_t dispin,
   output data_byte_t    dataout,
   output logic          k,
   output running_disp_t dispout,
   output logic          code_err,
   output logic          disp_err
);

   logic [9:0]    flat;
   logic [5:0]    six;
   logic [3:0]    four;
   logic [3:0]    four_lk;
   logic [4:0]    x;
   logic [2:0]    y;
   logic          valid6;
   logic          valid4;
   logic          k28;
   logic          a7_bad;
   logic          derr6;
   logic          derr4;
   int            n6;
   int            n4;
   running_disp_t rd6;

   always_comb
   begin
      for (int i = 0; i < 10; i++)
         flat[9-i] = datain[i];
      six = flat[9:4];
      four = flat[3:0];

      valid6 = 1'b1;
      x = 5'd0;
      case (six)
         6'b100111, 6'b011000: x = 5'd0;
         6'b011101, 6'b100010: x = 5'd1;
         6'b101101, 6'b010010: x = 5'd2;
         6'b110001:            x = 5'd3;
         6'b110101, 6'b001010: x = 5'd4;
         6'b101001:            x = 5'd5;
         6'b011001:            x = 5'd6;
         6'b111000, 6'b000111: x = 5'd7;
         6'b111001, 6'b000110: x = 5'd8;
         6'b100101:            x = 5'd9;
         6'b010101:            x = 5'd10;
         6'b110100:            x = 5'd11;
         6'b001101:            x = 5'd12;
         6'b101100:            x = 5'd13;
         6'b011100:            x = 5'd14;
         6'b010111, 6'b101000: x = 5'd15;
         6'b011011, 6'b100100: x = 5'd16;
         6'b100011:            x = 5'd17;
         6'b010011:            x = 5'd18;
         6'b110010:            x = 5'd19;
         6'b001011:            x = 5'd20;
         6'b101010:            x = 5'd21;
         6'b011010:            x = 5'd22;
         6'b111010, 6'b000101: x = 5'd23;
         6'b110011, 6'b001100: x = 5'd24;
         6'b100110:            x = 5'd25;
         6'b010110:            x = 5'd26;
         6'b110110, 6'b001001: x = 5'd27;
         6'b001110, 6'b001111, 6'b110000: x = 5'd28;
         6'b101110, 6'b010001: x = 5'd29;
         6'b011110, 6'b100001: x = 5'd30;
         6'b101011, 6'b010100: x = 5'd31;
         default: valid6 = 1'b0;
      endcase
      k28 = (six == 6'b001111) || (six == 6'b110000);

      // positive K28 form carries its 4b block inverted.
      four_lk = (six == 6'b110000) ? ~four : four;
      valid4 = 1'b1;
      y = 3'd0;
      case (four_lk)
         4'b1011, 4'b0100: y = 3'd0;
         4'b1001:          y = 3'd1;
         4'b0101:          y = 3'd2;
         4'b1100, 4'b0011: y = 3'd3;
         4'b1101, 4'b0010: y = 3'd4;
         4'b1010:          y = 3'd5;
         4'b0110:          y = 3'd6;
         4'b1110, 4'b0001, 4'b0111, 4'b1000: y = 3'd7;
         default: valid4 = 1'b0;
      endcase

      a7_bad = (four == 4'b0111 || four == 4'b1000) && !k28 &&
               !(x == 5'd11 || x == 5'd13 || x == 5'd14 ||
                 x == 5'd17 || x == 5'd18 || x == 5'd20);

      n6 = $countones(six);
      n4 = $countones(four);
      derr6 = ((n6 > 3) && dispin) || ((n6 < 3) && !dispin) ||
              ((six == 6'b111000) && dispin) || ((six == 6'b000111) && !dispin);
      rd6 = (n6 == 3) ? dispin : (n6 > 3);
      derr4 = ((n4 > 2) && rd6) || ((n4 < 2) && !rd6) ||
              ((four == 4'b1100) && rd6) || ((four == 4'b0011) && !rd6);

      dispout = (n4 == 2) ? rd6 : (n4 > 2);
      dataout = {y, x};
      code_err = !valid6 || !valid4 || a7_bad;
      disp_err = derr6 || derr4;
      k = k28 && valid4;
   end

   // a control group never also counts as a violation.
   always_comb
   begin
      assert (!(k && code_err));
   end

endmodule

// ==== hdl/time_sender.sv ====
`timescale 1ns/10ps
`include "time_link_config.svh"

module time_sender
   import line_code_pkg::*;
   import time_pkg::*;
(
   input  logic       clk,
   input  logic       rst,
   input  time_word_t master_time,
   input  logic       send_sync,
   output logic       serial_out
);

   localparam int NUM_BYTES = `TIME_WIDTH / 8;
   localparam send_state_t LAST_STATE = send_state_t'(SEND_T0 + NUM_BYTES - 1);

   time_word_t    master_time_reg;
   send_state_t   state;
   logic [3:0]    bit_count;
   logic          new_word;
   logic          k;
   data_byte_t    datain;
   data_byte_t    time_byte;
   code_group_t   dataout;
   code_group_t   shift_reg;
   running_disp_t disp_reg;
   running_disp_t disp_next;
   int            byte_idx;

   encode_8b10b encoder
   (
      .datain  (datain),
      .k       (k),
      .dispin  (disp_reg),
      .dataout (dataout),
      .dispout (disp_next)
   );

   assign serial_out = shift_reg[0];
   assign new_word = (bit_count == 4'd9);

   // byte position within the latched time, MSB first.
   assign byte_idx = (state >= SEND_T0) ? int'(state) - int'(SEND_T0) : 0;
   assign time_byte = master_time_reg[`TIME_WIDTH-1-8*byte_idx -: 8];

   always_ff @(posedge clk)
   begin
      if (send_sync)
         master_time_reg <= master_time;
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         bit_count <= 4'd0;
         shift_reg <= '0;
         disp_reg <= 1'b0;
      end
      else if (new_word)
      begin
         bit_count <= 4'd0;
         shift_reg <= dataout;
         disp_reg <= disp_next;
      end
      else
      begin
         bit_count <= bit_count + 4'd1;
         shift_reg <= {1'b0, shift_reg[`SYMBOL_BITS-1:1]};
      end
   end

   // a sync drops whatever frame is queued and starts over with a comma,
   // so the new frame begins on the next group boundary.
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         k <= 1'b0;
         datain <= 8'h00;
         state <= SEND_IDLE;
      end
      else if (send_sync)
      begin
         k <= 1'b1;
         datain <= `COMMA_CHAR;
         state <= SEND_HEAD;
      end
      else if (new_word)
      begin
         case (state)
            SEND_IDLE:
            begin
               k <= 1'b1;
               datain <= `COMMA_CHAR;
            end
            SEND_HEAD:
            begin
               k <= 1'b1;
               datain <= `HEAD_CHAR;
               state <= SEND_T0;
            end
            default:
            begin
               k <= 1'b0;
               datain <= time_byte;
               state <= (state == LAST_STATE) ? SEND_IDLE : send_state_t'(state + 1);
            end
         endcase
      end
   end

   assert property (@(posedge clk) disable iff (rst) bit_count <= 4'd9);
   assert property (@(posedge clk) disable iff (rst) send_sync |=> state == SEND_HEAD);

endmodule

// ==== hdl/time_receiver.sv ====
`timescale 1ns/10ps
`include "time_link_config.svh"

module time_receiver
   import line_code_pkg::*;
   import time_pkg::*;
(
   input  logic       clk,
   input  logic       rst,
   input  logic       serial_in,
   output time_word_t rx_time,
   output logic       rx_time_valid,
   output logic       rx_aligned,
   output logic       code_error
);

   localparam int NUM_BYTES = `TIME_WIDTH / 8;
   localparam int IDX_BITS = $clog2(NUM_BYTES);

   // K28.5 as it sits in the window after negative and positive disparity.
   localparam code_group_t COMMA_NEG = 10'h17C;
   localparam code_group_t COMMA_POS = 10'h283;

   code_group_t         window;
   logic [3:0]          sym_cnt;
   recv_state_t         state;
   running_disp_t       disp_reg;
   logic [IDX_BITS-1:0] byte_idx;
   time_word_t          time_acc;
   data_byte_t          dec_data;
   logic                dec_k;
   logic                dec_code_err;
   logic                dec_disp_err;
   running_disp_t       dec_disp;
   logic                comma_seen;
   logic                boundary;
   logic                realign;
   logic                ctrl_bad;
   logic                group_err;
   logic                last_byte;

   decode_8b10b decoder
   (
      .datain   (window),
      .dispin   (disp_reg),
      .dataout  (dec_data),
      .k        (dec_k),
      .dispout  (dec_disp),
      .code_err (dec_code_err),
      .disp_err (dec_disp_err)
   );

   assign rx_aligned = (state != RECV_HUNT);
   assign comma_seen = (window == COMMA_NEG) || (window == COMMA_POS);
   assign boundary = rx_aligned && (sym_cnt == 4'd9);
   // a comma off the current group boundary moves the alignment.
   assign realign = comma_seen && !boundary;

   // only a comma, or a header between frames, is an expected control group.
   assign ctrl_bad = dec_k && !(dec_data == `COMMA_CHAR ||
                     (dec_data == `HEAD_CHAR && state == RECV_WAIT_HEAD));
   assign group_err = dec_code_err || dec_disp_err || ctrl_bad;
   assign last_byte = (byte_idx == IDX_BITS'(NUM_BYTES - 1));

   // newest bit enters at the top.
   always_ff @(posedge clk)
   begin
      window <= {serial_in, window[`SYMBOL_BITS-1:1]};
   end

   always_ff @(posedge clk)
   begin
      if (boundary && !group_err && !dec_k && state == RECV_COLLECT)
         time_acc <= {time_acc[`TIME_WIDTH-9:0], dec_data};
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         state <= RECV_HUNT;
         sym_cnt <= 4'd0;
         disp_reg <= 1'b0;
         byte_idx <= '0;
         rx_time <= '0;
         rx_time_valid <= 1'b0;
         code_error <= 1'b0;
      end
      else
      begin
         rx_time_valid <= 1'b0;
         code_error <= 1'b0;
         sym_cnt <= (sym_cnt == 4'd9) ? 4'd0 : sym_cnt + 4'd1;
         if (realign)
         begin
            // disparity after the comma follows from the form it took.
            sym_cnt <= 4'd0;
            disp_reg <= (window == COMMA_NEG);
            byte_idx <= '0;
            state <= RECV_WAIT_HEAD;
         end
         else if (boundary)
         begin
            disp_reg <= dec_disp;
            if (group_err)
            begin
               code_error <= 1'b1;
               state <= RECV_HUNT;
            end
            else if (dec_k)
            begin
               byte_idx <= '0;
               state <= (dec_data == `HEAD_CHAR) ? RECV_COLLECT : RECV_WAIT_HEAD;
            end
            else if (state == RECV_COLLECT)
            begin
               byte_idx <= byte_idx + 1'b1;
               if (last_byte)
               begin
                  rx_time <= {time_acc[`TIME_WIDTH-9:0], dec_data};
                  rx_time_valid <= 1'b1;
                  state <= RECV_WAIT_HEAD;
               end
            end
         end
      end
   end

   assert property (@(posedge clk) disable iff (rst) rx_time_valid |-> rx_aligned);
   assert property (@(posedge clk) disable iff (rst) !(rx_time_valid && code_error));

endmodule

// ==== hdl/time_link.sv ====
`timescale 1ns/10ps

module time_link
   import time_pkg::*;
(
   input  logic       clk,
   input  logic       rst,
   input  time_word_t master_time,
   input  logic       send_sync,
   output logic       serial_out,
   input  logic       serial_in,
   output time_word_t rx_time,
   output logic       rx_time_valid,
   output logic       rx_aligned,
   output logic       code_error
);

   time_sender sender
   (
      .clk         (clk),
      .rst         (rst),
      .master_time (master_time),
      .send_sync   (send_sync),
      .serial_out  (serial_out)
   );

   // the line is closed outside, so the receiver may see a different stream.
   time_receiver receiver
   (
      .clk           (clk),
      .rst           (rst),
      .serial_in     (serial_in),
      .rx_time       (rx_time),
      .rx_time_valid (rx_time_valid),
      .rx_aligned    (rx_aligned),
      .code_error    (code_error)
   );

endmodule

// ==== bench/time_link_tb.sv ====
`timescale 1ns/10ps

module time_link_tb
   import time_pkg::*;
();

   localparam int RESET_CYCLES = 2;
   localparam int ALIGN_LIMIT = 40;
   localparam int MAX_LATENCY = 80;
   localparam int CORRUPT_START = 25;
   localparam int CORRUPT_LEN = 20;
   localparam GOLDEN_PATH = "bench/time_link_golden.txt";

   // line after reset is ten zeros, D0.0 in negative disparity, then K28.5.
   localparam logic [0:29] STARTUP_LINE = 30'b0000000000_1001110100_0011111010;

   typedef enum logic [1:0]
   {
      EXP_NONE,
      EXP_OK,
      EXP_ERR
   } outcome_t;

   logic       clk;
   logic       rst;
   time_word_t master_time;
   logic       send_sync;
   logic       serial_in;
   logic       serial_out;
   time_word_t rx_time;
   logic       rx_time_valid;
   logic       rx_aligned;
   logic       code_error;

   time_word_t gold_time[$];
   int         gold_gap[$];
   logic       gold_corrupt[$];
   outcome_t   gold_outcome[$];

   outcome_t   frame_outcome;
   time_word_t expected_time;
   time_word_t last_time;
   logic       corrupting;
   int         valid_count;
   int         err_count;
   int         cycle_count = 0;
   int         timeout_limit = 0;

   time_link uut
   (
      .clk           (clk),
      .rst           (rst),
      .master_time   (master_time),
      .send_sync     (send_sync),
      .serial_out    (serial_out),
      .serial_in     (serial_in),
      .rx_time       (rx_time),
      .rx_time_valid (rx_time_valid),
      .rx_aligned    (rx_aligned),
      .code_error    (code_error)
   );

   always #5 clk = ~clk;

   always @(posedge clk)
   begin
      cycle_count <= cycle_count + 1;
      if (timeout_limit > 0 && cycle_count >= timeout_limit)
      begin
         $display("run did not finish within %0d cycles", timeout_limit);
         abort_run();
      end
   end

   task automatic abort_run();
      $display("Finished with errors");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic report_problem(string msg);
      $display("%0t ns: %s", $time, msg);
      abort_run();
   endtask

   task automatic check_time(time_word_t actual, time_word_t expected, string what);
      if (actual !== expected)
      begin
         $display("[FAIL] %0t ns: %s is %h, expected %h", $time, what, actual, expected);
         abort_run();
      end
   endtask

   task automatic check_flag(logic actual, logic expected, string what);
      if (actual !== expected)
      begin
         $display("[FAIL] %0t ns: %s is %b, expected %b", $time, what, actual, expected);
         abort_run();
      end
   endtask

   // outputs settle after the rising edge, so they are read here.
   task automatic observe_outputs();
      if (rx_time_valid)
      begin
         if (frame_outcome != EXP_OK || valid_count != 0)
            report_problem("time word reported where none was expected");
         check_time(rx_time, expected_time, "rx_time");
         last_time = rx_time;
         valid_count++;
      end
      else
         check_time(rx_time, last_time, "rx_time between words");
      if (code_error)
      begin
         if (frame_outcome != EXP_ERR || err_count != 0)
            report_problem("code error reported on a clean line");
         check_flag(rx_aligned, 1'b0, "rx_aligned with code_error");
         err_count++;
      end
   endtask

   // the loopback closes the line on each falling edge.
   task automatic step();
      @(negedge clk);
      observe_outputs();
      serial_in = corrupting ? 1'b0 : serial_out;
   endtask

   task automatic read_golden();
      int          fd;
      int          n;
      int          gap;
      int          corrupt;
      string       line;
      time_word_t  value;
      logic [31:0] word;
      fd = $fopen(GOLDEN_PATH, "r");
      if (fd == 0)
         report_problem("cannot open the golden stimulus file");
      while ($fgets(line, fd) != 0)
      begin
         if (line.len() < 2 || line.getc(0) == "#")
            continue;
         n = $sscanf(line, "%h %d %d %s", value, gap, corrupt, word);
         if (n != 4)
            report_problem("malformed line in the golden stimulus file");
         gold_time.push_back(value);
         gold_gap.push_back(gap);
         gold_corrupt.push_back(corrupt != 0);
         if (word == "ok")
            gold_outcome.push_back(EXP_OK);
         else if (word == "err")
            gold_outcome.push_back(EXP_ERR);
         else if (word == "none")
            gold_outcome.push_back(EXP_NONE);
         else
            report_problem("unknown outcome in the golden stimulus file");
      end
      $fclose(fd);
   endtask

   task automatic run_frame(time_word_t value, int gap, logic corrupt, outcome_t outcome);
      int idle;
      idle = $urandom % 16;
      repeat (idle)
         step();
      frame_outcome = outcome;
      expected_time = value;
      valid_count = 0;
      err_count = 0;
      master_time = value;
      send_sync = 1'b1;
      step();
      send_sync = 1'b0;
      // the sender must keep the value it latched.
      master_time = ~value;
      for (int i = 1; i < gap; i++)
      begin
         corrupting = corrupt && (i >= CORRUPT_START) && (i < CORRUPT_START + CORRUPT_LEN);
         step();
         if (i == MAX_LATENCY && outcome == EXP_OK && valid_count == 0)
            report_problem("no time word received within 80 cycles of sync");
         if (i == MAX_LATENCY && outcome == EXP_ERR && err_count == 0)
            report_problem("no code error reported within 80 cycles of a corrupted sync");
      end
      corrupting = 1'b0;
      if (outcome == EXP_ERR)
         check_flag(rx_aligned, 1'b1, "rx_aligned after the corrupted frame");
   endtask

   initial
   begin
      int waited;
      clk = 1'b0;
      rst = 1'b1;
      master_time = '0;
      send_sync = 1'b0;
      serial_in = 1'b0;
      corrupting = 1'b0;
      frame_outcome = EXP_NONE;
      expected_time = '0;
      last_time = '0;
      valid_count = 0;
      err_count = 0;
      void'($urandom(32'h7bb6));
      read_golden();
      timeout_limit = 200;
      foreach (gold_gap[i])
         timeout_limit += gold_gap[i] + 100;

      repeat (RESET_CYCLES)
         step();
      rst = 1'b0;
      check_flag(rx_aligned, 1'b0, "rx_aligned after reset");

      // idle commas alone should bring the receiver into alignment.
      waited = 0;
      while (!rx_aligned && waited < ALIGN_LIMIT)
      begin
         if (waited < $bits(STARTUP_LINE))
            check_flag(serial_out, STARTUP_LINE[waited], "serial_out after reset");
         step();
         waited++;
      end
      if (!rx_aligned)
         report_problem("receiver did not align on idle commas within 40 cycles of reset");

      foreach (gold_time[i])
         run_frame(gold_time[i], gold_gap[i], gold_corrupt[i], gold_outcome[i]);

      $display("Finished with no errors");
      $finish;
   end

endmodule

// ==== bench/time_link_golden.txt ====
# columns: time value (hex), cycles until the next sync, corrupt flag, expected outcome
# a gap under 60 truncates the frame, so its outcome is none
00000000 100 0 ok
ffffffff 100 0 ok
aaaaaaaa 100 0 ok
55555555 100 0 ok
12345678 100 0 ok
0f0f0f0f 100 0 ok
f0f0f0f0 600 0 ok
deadbeef 25 0 none
cafef00d 100 0 ok
13579bdf 150 1 err
2468ace0 100 0 ok
bc3cbc3c 100 0 ok
80000001 30 0 none
7fffffff 20 0 none
00ff00ff 100 0 ok
a5a55a5a 150 1 err
f1f2f4eb 100 0 ok
fedcba98 100 0 ok
01010101 100 0 ok
ffffffff 520 0 ok

// ==== filelist.f ====
+incdir+hdl
hdl/line_code_pkg.sv
hdl/time_pkg.sv
hdl/encode_8b10b.sv
hdl/decode_8b10b.sv
hdl/time_sender.sv
hdl/time_receiver.sv
hdl/time_link.sv
bench/time_link_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the time link testbench with Verilator.

LOG=sim.log
OBJ_DIR=obj_dir

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   -f filelist.f --top-module time_link_tb \
   --Mdir "$OBJ_DIR" -o time_link_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

"./$OBJ_DIR/time_link_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Finished with errors" "$LOG"; then
   echo "simulation reported errors"
   exit 1
fi
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

echo "simulation passed"
exit 0
